// File: include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data bus and register width
`define CPU_DATA_W 8

// Address bus width
`define CPU_ADDR_W 16

// First opcode fetch after reset
`define CPU_RESET_PC 16'h0200

`endif

// File: source/isa_pkg.sv
`include "cpu_params.svh"

package isa_pkg;

  typedef logic [`CPU_DATA_W-1:0] byte_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;

  // Supported operations, anything else runs as OP_NOP
  typedef enum logic [5:0] {
    OP_NOP,
    OP_LDA, OP_LDX, OP_LDY,
    OP_STA, OP_STX, OP_STY,
    OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR,
    OP_CMP, OP_CPX, OP_CPY,
    OP_INX, OP_INY, OP_DEX, OP_DEY,
    OP_TAX, OP_TAY, OP_TXA, OP_TYA,
    OP_CLC, OP_SEC, OP_CLV,
    OP_BCC, OP_BCS, OP_BNE, OP_BEQ,
    OP_BVC, OP_BVS, OP_BPL, OP_BMI,
    OP_JMP
  } op_t;

  typedef enum logic [2:0] {
    AM_IMP,
    AM_ACC,
    AM_IMM,
    AM_ZPG,
    AM_ABS,
    AM_REL
  } addr_mode_t;

  // Kept subset of the processor status byte
  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } status_t;

  typedef enum logic [1:0] {
    FLAG_C,
    FLAG_Z,
    FLAG_V,
    FLAG_N
  } flag_sel_t;

endpackage

// File: source/ctrl_pkg.sv
package ctrl_pkg;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_OPER,
    ST_ABS_AM,
    ST_R_DATA,
    ST_W_DATA,
    ST_REL_AM,
    ST_REL_FIX
  } state_t;

  typedef enum logic [3:0] {
    ALU_PASS,
    ALU_ADC,
    ALU_SBC,
    ALU_AND,
    ALU_ORA,
    ALU_EOR,
    ALU_CMP,
    ALU_INC,
    ALU_DEC
  } alu_ctrl_t;

  typedef enum logic [1:0] {SRC_A_A, SRC_A_X, SRC_A_Y, SRC_A_T} alu_src_a_t;

  // DST_P marks flag-only ops such as CLC and SEC
  typedef enum logic [2:0] {DST_NONE, DST_A, DST_X, DST_Y, DST_P} reg_dst_t;

  typedef enum logic {REG_SRC_MEM, REG_SRC_ALU} reg_src_t;

  typedef enum logic [1:0] {P_SRC_NONE, P_SRC_ALU, P_SRC_SET, P_SRC_CLR} p_src_t;

  // Address register sources: next PC, page zero, or {data_in, T}
  typedef enum logic [1:0] {AB_SRC_PC, AB_SRC_ZPG, AB_SRC_T_MEM} ab_src_t;

  typedef enum logic [1:0] {PC_NOP, PC_INC, PC_ADD, PC_CADD} pc_ctrl_t;

  typedef enum logic [1:0] {DB_SRC_A, DB_SRC_X, DB_SRC_Y} db_src_t;

endpackage

// File: source/op_decoder.sv
`timescale 1ns/100ps

module op_decoder import isa_pkg::*, ctrl_pkg::*; (
  input  byte_t      instr,
  output op_t        op,
  output addr_mode_t addr_mode,
  output alu_ctrl_t  exe_ctrl,
  output alu_src_a_t exe_src_a,
  output reg_dst_t   exe_dst,
  output flag_sel_t  flag_sel,
  output logic       is_store
);

  always_comb begin
    case (instr)
      8'hA9, 8'hA5, 8'hAD: op = OP_LDA;
      8'hA2, 8'hA6, 8'hAE: op = OP_LDX;
      8'hA0, 8'hA4, 8'hAC: op = OP_LDY;
      8'h85, 8'h8D:        op = OP_STA;
      8'h86, 8'h8E:        op = OP_STX;
      8'h84, 8'h8C:        op = OP_STY;
      8'h69, 8'h65, 8'h6D: op = OP_ADC;
      8'hE9, 8'hE5, 8'hED: op = OP_SBC;
      8'h29, 8'h25, 8'h2D: op = OP_AND;
      8'h09, 8'h05, 8'h0D: op = OP_ORA;
      8'h49, 8'h45, 8'h4D: op = OP_EOR;
      8'hC9, 8'hC5, 8'hCD: op = OP_CMP;
      8'hE0, 8'hE4, 8'hEC: op = OP_CPX;
      8'hC0, 8'hC4, 8'hCC: op = OP_CPY;
      8'hE8: op = OP_INX;
      8'hC8: op = OP_INY;
      8'hCA: op = OP_DEX;
      8'h88: op = OP_DEY;
      8'hAA: op = OP_TAX;
      8'hA8: op = OP_TAY;
      8'h8A: op = OP_TXA;
      8'h98: op = OP_TYA;
      8'h18: op = OP_CLC;
      8'h38: op = OP_SEC;
      8'hB8: op = OP_CLV;
      8'h10: op = OP_BPL;
      8'h30: op = OP_BMI;
      8'h50: op = OP_BVC;
      8'h70: op = OP_BVS;
      8'h90: op = OP_BCC;
      8'hB0: op = OP_BCS;
      8'hD0: op = OP_BNE;
      8'hF0: op = OP_BEQ;
      8'h4C: op = OP_JMP;
      default: op = OP_NOP;
    endcase

    // Mode follows the bbb field of the opcode for the kept ops
    if (op == OP_NOP)
      addr_mode = AM_IMP;
    else
      case (instr[4:2])
        3'b000:  addr_mode = AM_IMM;
        3'b001:  addr_mode = AM_ZPG;
        3'b010:  addr_mode = instr[0] ? AM_IMM : AM_IMP;
        3'b011:  addr_mode = AM_ABS;
        3'b100:  addr_mode = AM_REL;
        default: addr_mode = AM_IMP;
      endcase
  end

  // Execute recipe, applied while the next opcode is fetched
  always_comb begin
    case (op)
      OP_ADC:                 exe_ctrl = ALU_ADC;
      OP_SBC:                 exe_ctrl = ALU_SBC;
      OP_AND:                 exe_ctrl = ALU_AND;
      OP_ORA:                 exe_ctrl = ALU_ORA;
      OP_EOR:                 exe_ctrl = ALU_EOR;
      OP_CMP, OP_CPX, OP_CPY: exe_ctrl = ALU_CMP;
      OP_INX, OP_INY:         exe_ctrl = ALU_INC;
      OP_DEX, OP_DEY:         exe_ctrl = ALU_DEC;
      default:                exe_ctrl = ALU_PASS;
    endcase

    case (op)
      OP_LDA, OP_LDX, OP_LDY:         exe_src_a = SRC_A_T;
      OP_CPX, OP_INX, OP_DEX, OP_TXA: exe_src_a = SRC_A_X;
      OP_CPY, OP_INY, OP_DEY, OP_TYA: exe_src_a = SRC_A_Y;
      default:                        exe_src_a = SRC_A_A;
    endcase

    case (op)
      OP_LDA, OP_TXA, OP_TYA, OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR: exe_dst = DST_A;
      OP_LDX, OP_TAX, OP_INX, OP_DEX: exe_dst = DST_X;
      OP_LDY, OP_TAY, OP_INY, OP_DEY: exe_dst = DST_Y;
      OP_CLC, OP_SEC, OP_CLV:         exe_dst = DST_P;
      default:                        exe_dst = DST_NONE;
    endcase

    // ADC and SBC name V so the status register takes the overflow
    case (op)
      OP_BNE, OP_BEQ:                         flag_sel = FLAG_Z;
      OP_BVC, OP_BVS, OP_CLV, OP_ADC, OP_SBC: flag_sel = FLAG_V;
      OP_BPL, OP_BMI:                         flag_sel = FLAG_N;
      default:                                flag_sel = FLAG_C;
    endcase
  end

  assign is_store = (op == OP_STA) || (op == OP_STX) || (op == OP_STY);

endmodule

// File: source/sequencer.sv
`timescale 1ns/100ps

module sequencer import isa_pkg::*, ctrl_pkg::*; (
  input  logic       CLK,
  input  logic       rst,
  input  logic       rdy,
  input  byte_t      data_in,
  input  status_t    status,
  input  logic       pc_carry,
  output logic       r_w,
  output db_src_t    db_src,
  output pc_ctrl_t   pc_ctrl,
  output logic       pc_load_mem,
  output logic       pc_we,
  output ab_src_t    ab_src,
  output logic       ab_we,
  output reg_src_t   reg_src,
  output logic       a_we,
  output logic       x_we,
  output logic       y_we,
  output logic       t_we,
  output p_src_t     p_src,
  output flag_sel_t  p_flag,
  output alu_ctrl_t  alu_ctrl,
  output alu_src_a_t alu_src_a
);

  byte_t      ir;
  logic       ir_we;
  state_t     state;
  state_t     state_nxt;
  op_t        op;
  addr_mode_t addr_mode;
  alu_ctrl_t  exe_ctrl;
  alu_src_a_t exe_src_a;
  reg_dst_t   exe_dst;
  flag_sel_t  flag_sel;
  logic       is_store;
  logic       flag_val;
  logic       taken;

  op_decoder u_decoder (
    .instr     (ir),
    .op        (op),
    .addr_mode (addr_mode),
    .exe_ctrl  (exe_ctrl),
    .exe_src_a (exe_src_a),
    .exe_dst   (exe_dst),
    .flag_sel  (flag_sel),
    .is_store  (is_store)
  );

  always_comb begin
    case (flag_sel)
      FLAG_C:  flag_val = status.c;
      FLAG_Z:  flag_val = status.z;
      FLAG_V:  flag_val = status.v;
      default: flag_val = status.n;
    endcase
  end

  // BCS, BEQ, BVS and BMI go on a set flag, the others on a clear one
  assign taken = (addr_mode == AM_REL) &&
                 (flag_val == (op inside {OP_BCS, OP_BEQ, OP_BVS, OP_BMI}));

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= ST_FETCH;
      ir    <= '0;
    end else begin
      if (rdy)
        state <= state_nxt;
      if (ir_we)
        ir <= data_in;
    end
  end

  always_comb begin
    case (state)
      ST_FETCH: state_nxt = ST_OPER;
      ST_OPER:
        case (addr_mode)
          AM_ZPG:  state_nxt = is_store ? ST_W_DATA : ST_R_DATA;
          AM_ABS:  state_nxt = ST_ABS_AM;
          AM_REL:  state_nxt = taken ? ST_REL_AM : ST_FETCH;
          default: state_nxt = ST_FETCH;
        endcase
      ST_ABS_AM:
        if (op == OP_JMP)
          state_nxt = ST_FETCH;
        else
          state_nxt = is_store ? ST_W_DATA : ST_R_DATA;
      ST_REL_AM: state_nxt = pc_carry ? ST_REL_FIX : ST_FETCH;
      default:   state_nxt = ST_FETCH;
    endcase
  end

  always_comb begin
    r_w         = 1'b1;
    db_src      = DB_SRC_A;
    pc_ctrl     = PC_NOP;
    pc_load_mem = 1'b0;
    pc_we       = 1'b0;
    ab_src      = AB_SRC_PC;
    ab_we       = 1'b0;
    reg_src     = REG_SRC_MEM;
    ir_we       = 1'b0;
    a_we        = 1'b0;
    x_we        = 1'b0;
    y_we        = 1'b0;
    t_we        = 1'b0;
    p_src       = P_SRC_NONE;
    p_flag      = flag_sel;
    alu_ctrl    = ALU_PASS;
    alu_src_a   = SRC_A_A;

    case (state)
      ST_FETCH: begin
        ir_we   = 1'b1;
        pc_ctrl = PC_INC;
        pc_we   = 1'b1;
        ab_we   = 1'b1;
        // Retire the previous instruction
        alu_ctrl  = exe_ctrl;
        alu_src_a = exe_src_a;
        reg_src   = REG_SRC_ALU;
        a_we      = (exe_dst == DST_A);
        x_we      = (exe_dst == DST_X);
        y_we      = (exe_dst == DST_Y);
        if (exe_dst == DST_P)
          p_src = (op == OP_SEC) ? P_SRC_SET : P_SRC_CLR;
        else if (exe_dst != DST_NONE || exe_ctrl == ALU_CMP)
          p_src = P_SRC_ALU;
      end
      ST_OPER: begin
        // Implied ops leave PC on the next opcode
        pc_ctrl = (addr_mode inside {AM_IMP, AM_ACC}) ? PC_NOP : PC_INC;
        pc_we   = 1'b1;
        t_we    = 1'b1;
        ab_we   = 1'b1;
        if (addr_mode == AM_ZPG)
          ab_src = AB_SRC_ZPG;
      end
      ST_ABS_AM: begin
        pc_ctrl     = PC_INC;
        pc_we       = 1'b1;
        pc_load_mem = (op == OP_JMP);
        ab_src      = AB_SRC_T_MEM;
        ab_we       = 1'b1;
      end
      ST_R_DATA: begin
        t_we  = 1'b1;
        ab_we = 1'b1;
      end
      ST_W_DATA: begin
        r_w   = 1'b0;
        ab_we = 1'b1;
        if (op == OP_STX)
          db_src = DB_SRC_X;
        else if (op == OP_STY)
          db_src = DB_SRC_Y;
      end
      ST_REL_AM: begin
        pc_ctrl = PC_ADD;
        pc_we   = 1'b1;
        ab_we   = 1'b1;
      end
      ST_REL_FIX: begin
        pc_ctrl = PC_CADD;
        pc_we   = 1'b1;
        ab_we   = 1'b1;
      end
      default: ;
    endcase

    // Stall holds every register, a write cycle simply repeats
    if (!rdy) begin
      ir_we = 1'b0;
      pc_we = 1'b0;
      ab_we = 1'b0;
      a_we  = 1'b0;
      x_we  = 1'b0;
      y_we  = 1'b0;
      t_we  = 1'b0;
      p_src = P_SRC_NONE;
    end
  end

endmodule

// File: source/alu.sv
`timescale 1ns/100ps

module alu import isa_pkg::*, ctrl_pkg::*; (
  input  alu_ctrl_t  alu_ctrl,
  input  alu_src_a_t alu_src_a,
  input  byte_t      a_val,
  input  byte_t      x_val,
  input  byte_t      y_val,
  input  byte_t      t_val,
  input  logic       carry_in,
  output byte_t      result,
  output status_t    flags
);

  localparam int DW = $bits(byte_t);

  byte_t       op_a;
  byte_t       op_b;
  logic        cin;
  logic [DW:0] sum;

  always_comb begin
    case (alu_src_a)
      SRC_A_X: op_a = x_val;
      SRC_A_Y: op_a = y_val;
      SRC_A_T: op_a = t_val;
      default: op_a = a_val;
    endcase
  end

  // Subtraction adds the inverted operand, carry set means no borrow
  assign op_b = (alu_ctrl inside {ALU_SBC, ALU_CMP}) ? ~t_val : t_val;
  assign cin  = (alu_ctrl == ALU_CMP) ? 1'b1 : carry_in;
  assign sum  = {1'b0, op_a} + {1'b0, op_b} + {{DW{1'b0}}, cin};

  always_comb begin
    result  = op_a;
    flags.c = carry_in;
    // Only ADC and SBC let V reach the status register
    flags.v = 1'b0;
    case (alu_ctrl)
      ALU_ADC, ALU_SBC: begin
        result  = sum[DW-1:0];
        flags.c = sum[DW];
        flags.v = (op_a[DW-1] == op_b[DW-1]) && (sum[DW-1] != op_a[DW-1]);
      end
      ALU_CMP: begin
        result  = sum[DW-1:0];
        flags.c = sum[DW];
      end
      ALU_AND: result = op_a & t_val;
      ALU_ORA: result = op_a | t_val;
      ALU_EOR: result = op_a ^ t_val;
      ALU_INC: result = op_a + 1'b1;
      ALU_DEC: result = op_a - 1'b1;
      default: result = op_a;
    endcase
    flags.z = (result == '0);
    flags.n = result[DW-1];
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/100ps

module reg_file import isa_pkg::*, ctrl_pkg::*; (
  input  logic      CLK,
  input  logic      rst,
  input  byte_t     data_in,
  input  byte_t     alu_result,
  input  status_t   alu_flags,
  input  reg_src_t  reg_src,
  input  logic      a_we,
  input  logic      x_we,
  input  logic      y_we,
  input  logic      t_we,
  input  p_src_t    p_src,
  input  flag_sel_t p_flag,
  input  db_src_t   db_src,
  output byte_t     a_val,
  output byte_t     x_val,
  output byte_t     y_val,
  output byte_t     t_val,
  output status_t   status,
  output byte_t     data_out
);

  byte_t wb_data;
  logic  flag_set;

  assign wb_data  = (reg_src == REG_SRC_ALU) ? alu_result : data_in;
  assign flag_set = (p_src == P_SRC_SET);

  always_ff @(posedge CLK) begin
    if (rst) begin
      a_val  <= '0;
      x_val  <= '0;
      y_val  <= '0;
      t_val  <= '0;
      status <= '0;
    end else begin
      if (a_we)
        a_val <= wb_data;
      if (x_we)
        x_val <= wb_data;
      if (y_we)
        y_val <= wb_data;
      if (t_we)
        t_val <= wb_data;
      case (p_src)
        P_SRC_ALU: begin
          // Loads and transfers pass through the ALU and land here for Z and N
          status.n <= alu_flags.n;
          status.z <= alu_flags.z;
          status.c <= alu_flags.c;
          if (p_flag == FLAG_V)
            status.v <= alu_flags.v;
        end
        P_SRC_SET, P_SRC_CLR: begin
          case (p_flag)
            FLAG_C:  status.c <= flag_set;
            FLAG_Z:  status.z <= flag_set;
            FLAG_V:  status.v <= flag_set;
            default: status.n <= flag_set;
          endcase
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (db_src)
      DB_SRC_X: data_out = x_val;
      DB_SRC_Y: data_out = y_val;
      default:  data_out = a_val;
    endcase
  end

endmodule

// File: source/pc_addr_unit.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module pc_addr_unit import isa_pkg::*, ctrl_pkg::*; (
  input  logic     CLK,
  input  logic     rst,
  input  pc_ctrl_t pc_ctrl,
  input  logic     pc_load_mem,
  input  logic     pc_we,
  input  ab_src_t  ab_src,
  input  logic     ab_we,
  input  byte_t    data_in,
  input  byte_t    t_val,
  output addr_t    addr,
  output logic     pc_carry
);

  localparam int    DW        = `CPU_DATA_W;
  localparam int    AW        = `CPU_ADDR_W;
  localparam addr_t PAGE_STEP = addr_t'(1) << DW;

  addr_t       pc;
  addr_t       pc_next;
  addr_t       ab_next;
  logic [DW:0] lo_sum;

  // Branch offset added to the low byte only
  assign lo_sum = {1'b0, pc[DW-1:0]} + {1'b0, t_val};

  // Page crossed when the carry out disagrees with the offset sign
  assign pc_carry = lo_sum[DW] ^ t_val[DW-1];

  always_comb begin
    case (pc_ctrl)
      PC_INC:  pc_next = pc + 1'b1;
      PC_ADD:  pc_next = {pc[AW-1:DW], lo_sum[DW-1:0]};
      PC_CADD: pc_next = t_val[DW-1] ? pc - PAGE_STEP : pc + PAGE_STEP;
      default: pc_next = pc;
    endcase
  end

  always_comb begin
    case (ab_src)
      AB_SRC_ZPG:   ab_next = {{(AW - DW){1'b0}}, data_in};
      AB_SRC_T_MEM: ab_next = {data_in, t_val};
      default:      ab_next = pc_next;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc   <= `CPU_RESET_PC;
      addr <= `CPU_RESET_PC;
    end else begin
      if (pc_we)
        pc <= pc_load_mem ? {data_in, t_val} : pc_next;
      if (ab_we)
        addr <= ab_next;
    end
  end

endmodule

// File: source/cpu_core.sv
`timescale 1ns/100ps

module cpu_core import isa_pkg::*, ctrl_pkg::*; (
  input  logic  CLK,
  input  logic  rst,
  input  logic  rdy,
  input  byte_t data_in,
  output addr_t addr,
  output byte_t data_out,
  output logic  r_w
);

  // Sequencer controls
  db_src_t    db_src;
  pc_ctrl_t   pc_ctrl;
  logic       pc_load_mem;
  logic       pc_we;
  ab_src_t    ab_src;
  logic       ab_we;
  reg_src_t   reg_src;
  logic       a_we;
  logic       x_we;
  logic       y_we;
  logic       t_we;
  p_src_t     p_src;
  flag_sel_t  p_flag;
  alu_ctrl_t  alu_ctrl;
  alu_src_a_t alu_src_a;

  // Datapath values
  byte_t      a_val;
  byte_t      x_val;
  byte_t      y_val;
  byte_t      t_val;
  byte_t      alu_result;
  status_t    alu_flags;
  status_t    status;
  logic       pc_carry;

  sequencer u_sequencer (.*);

  alu u_alu (
    .*,
    .carry_in (status.c),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  reg_file u_reg_file (.*);

  pc_addr_unit u_pc_addr_unit (.*);

endmodule

// File: sim/tb_cpu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module tb_cpu import isa_pkg::*; ();

  localparam int NTEST   = 9;
  localparam int PLEN    = 32;
  localparam int ALEN    = 16;
  localparam int TIMEOUT = 500;

  logic  CLK;
  logic  rst;
  logic  rdy;
  byte_t data_in;
  byte_t data_out;
  addr_t addr;
  logic  r_w;

  byte_t mem [0:65535];

  // Test table with programs at the reset PC, an extra block and expected results
  string name_tbl  [NTEST];
  byte_t prog_tbl  [NTEST][PLEN];
  byte_t aux_tbl   [NTEST][ALEN];
  addr_t aux_base  [NTEST];
  byte_t exp_tbl   [NTEST][3];
  logic  stall_tbl [NTEST];

  int          cur;
  int          pix;
  int          aix;
  logic [15:0] lfsr;
  addr_t       wr_addr_q[$];
  logic        done;
  logic        pend;
  addr_t       pend_addr;
  byte_t       pend_data;
  int          stall_errs;
  int          errs;
  int          fails;

  cpu_core i_dut (
    .CLK      (CLK),
    .rst      (rst),
    .rdy      (rdy),
    .data_in  (data_in),
    .addr     (addr),
    .data_out (data_out),
    .r_w      (r_w)
  );

  always #10 CLK = ~CLK;

  // Memory reads are combinational and writes land on the rising edge
  assign data_in = mem[addr];

  always @(posedge CLK) begin
    if (!rst && !r_w) begin
      mem[addr] <= data_out;
      if (pend && (addr !== pend_addr || data_out !== pend_data)) begin
        $display("Bus write changed while the core was stalled at address %h", addr);
        stall_errs++;
      end
      if (rdy) begin
        pend <= 1'b0;
        wr_addr_q.push_back(addr);
        if (addr == 16'h00FF)
          done <= 1'b1;
      end else begin
        pend      <= 1'b1;
        pend_addr <= addr;
        pend_data <= data_out;
      end
    end
  end

  // Galois LFSR stepped once per bit
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    return b;
  endfunction

  function automatic byte_t rand_byte();
    byte_t v;
    for (int k = 0; k < 8; k++)
      v[k] = next_bit();
    return v;
  endfunction

  // 6502 binary add with the carry out on bit 8
  function automatic logic [8:0] add_c(input byte_t x, input byte_t y, input logic cin);
    return {1'b0, x} + {1'b0, y} + {8'h00, cin};
  endfunction

  task automatic start_entry(input string name, input logic stall);
    cur++;
    pix = 0;
    aix = 0;
    name_tbl[cur]  = name;
    stall_tbl[cur] = stall;
    aux_base[cur]  = 16'h0400;
    for (int k = 0; k < PLEN; k++)
      prog_tbl[cur][k] = 8'hEA;
    for (int k = 0; k < ALEN; k++)
      aux_tbl[cur][k] = 8'hEA;
  endtask

  task automatic put(input logic in_aux, input byte_t b);
    if (in_aux) begin
      aux_tbl[cur][aix] = b;
      aix++;
    end else begin
      prog_tbl[cur][pix] = b;
      pix++;
    end
  endtask

  task automatic put_two(input logic in_aux, input byte_t b0, input byte_t b1);
    put(in_aux, b0);
    put(in_aux, b1);
  endtask

  task automatic put_three(input logic in_aux, input byte_t b0, input byte_t b1,
                           input byte_t b2);
    put(in_aux, b0);
    put(in_aux, b1);
    put(in_aux, b2);
  endtask

  // Final marker store followed by a JMP to itself
  task automatic end_prog(input logic in_aux);
    addr_t here;
    put_two(in_aux, 8'h85, 8'hFF);
    here = in_aux ? aux_base[cur] + aix : `CPU_RESET_PC + pix;
    put_three(in_aux, 8'h4C, here[7:0], here[15:8]);
  endtask

  task automatic add_sbc_entry(input string name, input logic stall,
                               input byte_t a, input byte_t b, input byte_t c);
    logic [8:0] s1;
    logic [8:0] s2;
    s1 = add_c(a, b, 1'b0);
    s2 = add_c(s1[7:0], ~c, s1[8]);
    start_entry(name, stall);
    put(0, 8'h18);
    put_two(0, 8'hA9, a);
    put_two(0, 8'h69, b);
    put_two(0, 8'h85, 8'h10);
    put_two(0, 8'hE9, c);
    put_two(0, 8'h85, 8'h11);
    // Carry set skips the second marker load
    put_two(0, 8'hA9, 8'h01);
    put_two(0, 8'hB0, 8'h02);
    put_two(0, 8'hA9, 8'h02);
    put_two(0, 8'h85, 8'h12);
    end_prog(0);
    exp_tbl[cur][0] = s1[7:0];
    exp_tbl[cur][1] = s2[7:0];
    exp_tbl[cur][2] = s2[8] ? 8'h01 : 8'h02;
  endtask

  task automatic index_entry(input string name, input byte_t x, input byte_t y);
    start_entry(name, 1'b0);
    put_two(0, 8'hA2, x);
    put(0, 8'hE8);
    put(0, 8'hE8);
    put(0, 8'h8A);
    put_two(0, 8'h85, 8'h10);
    put_two(0, 8'hA0, y);
    put(0, 8'h88);
    put(0, 8'h98);
    put_two(0, 8'h85, 8'h11);
    put_two(0, 8'h86, 8'h12);
    end_prog(0);
    exp_tbl[cur][0] = x + 8'd2;
    exp_tbl[cur][1] = y - 8'd1;
    exp_tbl[cur][2] = x + 8'd2;
  endtask

  task automatic build_table();
    byte_t      a;
    byte_t      b;
    byte_t      c;
    byte_t      d;
    byte_t      ar_a;
    byte_t      ar_b;
    byte_t      ar_c;
    logic [8:0] s1;
    logic [8:0] s2;
    cur = -1;

    a = rand_byte();
    b = rand_byte();
    c = rand_byte();
    start_entry("load_store", 1'b0);
    put_two(0, 8'hA9, a);
    put_two(0, 8'hA2, b);
    put_two(0, 8'hA0, c);
    put_two(0, 8'h85, 8'h10);
    put_two(0, 8'h86, 8'h11);
    put_two(0, 8'h84, 8'h12);
    end_prog(0);
    exp_tbl[cur][0] = a;
    exp_tbl[cur][1] = b;
    exp_tbl[cur][2] = c;

    ar_a = rand_byte();
    ar_b = rand_byte();
    ar_c = rand_byte();
    add_sbc_entry("clc_adc_sbc", 1'b0, ar_a, ar_b, ar_c);

    a = rand_byte();
    b = rand_byte();
    c = rand_byte();
    d = rand_byte();
    start_entry("and_ora_eor", 1'b0);
    put_two(0, 8'hA9, a);
    put_two(0, 8'h29, b);
    put_two(0, 8'h85, 8'h10);
    put_two(0, 8'h09, c);
    put_two(0, 8'h85, 8'h11);
    put_two(0, 8'h49, d);
    put_two(0, 8'h85, 8'h12);
    end_prog(0);
    exp_tbl[cur][0] = a & b;
    exp_tbl[cur][1] = (a & b) | c;
    exp_tbl[cur][2] = ((a & b) | c) ^ d;

    a = rand_byte();
    b = rand_byte();
    c = rand_byte();
    s1 = add_c(a, ~b, 1'b1);
    s2 = add_c(s1[7:0], c, s1[8]);
    start_entry("sec_sbc_adc", 1'b0);
    put(0, 8'h38);
    put_two(0, 8'hA9, a);
    put_two(0, 8'hE9, b);
    put_two(0, 8'h85, 8'h10);
    put_two(0, 8'h69, c);
    put_two(0, 8'h85, 8'h11);
    put_two(0, 8'hA9, 8'h01);
    put_two(0, 8'h90, 8'h02);
    put_two(0, 8'hA9, 8'h02);
    put_two(0, 8'h85, 8'h12);
    end_prog(0);
    exp_tbl[cur][0] = s1[7:0];
    exp_tbl[cur][1] = s2[7:0];
    exp_tbl[cur][2] = s2[8] ? 8'h02 : 8'h01;

    index_entry("index_wrap", 8'hFE, 8'h00);
    index_entry("index_rand", rand_byte(), rand_byte());

    // Table bytes at 0x0300 and a JMP over a trap store to 0x13
    a = rand_byte();
    b = rand_byte();
    start_entry("abs_jmp", 1'b0);
    aux_base[cur] = 16'h0300;
    put(1, a);
    put(1, b);
    put_three(0, 8'hAD, 8'h00, 8'h03);
    put_three(0, 8'h8D, 8'h10, 8'h00);
    put_three(0, 8'h4C, 8'h0B, 8'h02);
    put_two(0, 8'h85, 8'h13);
    put_three(0, 8'h8D, 8'h11, 8'h00);
    put_three(0, 8'hAC, 8'h01, 8'h03);
    put_two(0, 8'h84, 8'h12);
    end_prog(0);
    exp_tbl[cur][0] = a;
    exp_tbl[cur][1] = a;
    exp_tbl[cur][2] = b;

    a = rand_byte();
    start_entry("branches", 1'b0);
    aux_base[cur] = 16'h02F8;
    put_two(0, 8'hA2, 8'h01);
    put_two(0, 8'hA9, a);
    put_two(0, 8'hC9, a);
    put_two(0, 8'hF0, 8'h02);
    put_two(0, 8'hA2, 8'h04);
    // Z still set so BNE falls through to the INX
    put_two(0, 8'hD0, 8'h01);
    put(0, 8'hE8);
    put_two(0, 8'h86, 8'h10);
    put_two(0, 8'hC9, a ^ 8'h01);
    put_two(0, 8'hF0, 8'h02);
    put_two(0, 8'hA2, 8'h03);
    put_two(0, 8'h86, 8'h11);
    put_three(0, 8'h4C, 8'hF8, 8'h02);
    // BNE at 0x02FC lands on 0x0300 in the next page
    put_two(1, 8'hA2, 8'h04);
    put_two(1, 8'hC9, a ^ 8'h01);
    put_two(1, 8'hD0, 8'h02);
    put_two(1, 8'hA2, 8'h05);
    put_two(1, 8'h86, 8'h12);
    end_prog(1);
    exp_tbl[cur][0] = 8'h02;
    exp_tbl[cur][1] = 8'h03;
    exp_tbl[cur][2] = 8'h04;

    add_sbc_entry("rdy_stall", 1'b1, ar_a, ar_b, ar_c);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic run_test(input int i);
    addr_t a;
    int    cyc;
    for (int k = 0; k < 65536; k++) begin
      a = k;
      mem[k] = a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
    end
    for (int k = 0; k < PLEN; k++)
      mem[`CPU_RESET_PC + k] = prog_tbl[i][k];
    for (int k = 0; k < ALEN; k++)
      mem[aux_base[i] + k] = aux_tbl[i][k];
    wr_addr_q.delete();
    done       = 1'b0;
    pend       = 1'b0;
    stall_errs = 0;
    errs       = 0;

    @(posedge CLK);
    #2;
    rst = 1'b1;
    rdy = 1'b1;
    repeat (5) @(posedge CLK);
    #2;
    rst = 1'b0;

    cyc = 0;
    while (!done && cyc < TIMEOUT) begin
      @(posedge CLK);
      #2;
      if (!done)
        rdy = stall_tbl[i] ? next_bit() : 1'b1;
      cyc++;
    end
    rdy = 1'b1;

    if (!done) begin
      $display("Test %s timed out waiting for the final store to 00ff", name_tbl[i]);
      errs++;
    end else begin
      for (int k = 0; k < 3; k++)
        check_byte($sformatf("mem[%h]", 16'h0010 + k), mem[16'h0010 + k], exp_tbl[i][k]);
      if (wr_addr_q.size() != 4) begin
        $display("Test %s made %0d bus writes instead of 4", name_tbl[i], wr_addr_q.size());
        errs++;
      end else begin
        for (int k = 0; k < 3; k++)
          check_addr($sformatf("write %0d addr", k), wr_addr_q[k], 16'h0010 + k);
      end
    end
    errs += stall_errs;

    if (errs == 0) begin
      $display("test %0d %s: ok", i, name_tbl[i]);
    end else begin
      $display("test %0d %s: %0d errors", i, name_tbl[i], errs);
      fails++;
    end
  endtask

  initial begin
    CLK   = 1'b0;
    rst   = 1'b1;
    rdy   = 1'b1;
    lfsr  = 16'd53;
    fails = 0;
    build_table();
    for (int i = 0; i < NTEST; i++)
      run_test(i);
    $display("%0d tests run, %0d passed, %0d failed", NTEST, NTEST - fails, fails);
    if (fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
source/isa_pkg.sv
source/ctrl_pkg.sv
source/op_decoder.sv
source/sequencer.sv
source/alu.sv
source/reg_file.sv
source/pc_addr_unit.sv
source/cpu_core.sv
sim/tb_cpu.sv
